//--- design/hart.sv
`timescale 1ns/10ps

module hart import hart_pkg::*; #(
  parameter logic [xlen-1:0] RESET_ADDR = '0 // first fetch address after reset
) (
  input  logic                  i_clk,
  input  logic                  i_rst,
  output logic [xlen-1:0]       o_imem_raddr,
  input  logic [xlen-1:0]       i_imem_rdata,
  output logic [xlen-1:0]       o_dmem_addr,
  output logic                  o_dmem_ren,
  output logic                  o_dmem_wen,
  output logic [xlen-1:0]       o_dmem_wdata,
  output logic [3:0]            o_dmem_mask,
  input  logic [xlen-1:0]       i_dmem_rdata,
  output logic                  o_retire_valid,
  output logic [xlen-1:0]       o_retire_inst,
  output logic                  o_retire_halt,
  output logic [reg_addr_w-1:0] o_retire_rs1_raddr,
  output logic [reg_addr_w-1:0] o_retire_rs2_raddr,
  output logic [xlen-1:0]       o_retire_rs1_rdata,
  output logic [xlen-1:0]       o_retire_rs2_rdata,
  output logic [reg_addr_w-1:0] o_retire_rd_waddr,
  output logic [xlen-1:0]       o_retire_rd_wdata,
  output logic [xlen-1:0]       o_retire_pc,
  output logic [xlen-1:0]       o_retire_next_pc
);

  logic [reg_addr_w-1:0] rs1_addr, rs2_addr, rd_addr;
  logic [xlen-1:0]       rs1_data, rs2_data, imm;
  logic [3:0]            alu_op;
  logic                  alu_src_imm, alu_src_pc;
  logic                  branch, jal, jalr, halt;
  logic                  mem_read, mem_write, reg_write;
  logic [1:0]            wb_sel;
  logic [xlen-1:0]       pc, pc4, next_pc, alu_result;
  logic                  valid;
  logic                  rd_wen;
  logic [xlen-1:0]       rd_wdata;

  hart_decode decode_i (
    .i_inst(i_imem_rdata), .o_rs1_addr(rs1_addr), .o_rs2_addr(rs2_addr), .o_rd_addr(rd_addr),
    .o_imm(imm), .o_alu_op(alu_op), .o_alu_src_imm(alu_src_imm), .o_alu_src_pc(alu_src_pc),
    .o_branch(branch), .o_jal(jal), .o_jalr(jalr), .o_mem_read(mem_read),
    .o_mem_write(mem_write), .o_reg_write(reg_write), .o_wb_sel(wb_sel), .o_halt(halt)
  );

  hart_regfile regfile_i (
    .i_clk(i_clk), .i_rst(i_rst), .i_rs1_addr(rs1_addr), .i_rs2_addr(rs2_addr),
    .i_rd_addr(rd_addr), .i_rd_wen(rd_wen), .i_rd_wdata(rd_wdata),
    .o_rs1_rdata(rs1_data), .o_rs2_rdata(rs2_data)
  );

  hart_execute #(.RESET_ADDR(RESET_ADDR)) execute_i (
    .i_clk(i_clk), .i_rst(i_rst), .i_halt(halt), .i_rs1_data(rs1_data),
    .i_rs2_data(rs2_data), .i_imm(imm), .i_alu_op(alu_op), .i_alu_src_imm(alu_src_imm),
    .i_alu_src_pc(alu_src_pc), .i_branch(branch), .i_jal(jal), .i_jalr(jalr),
    .i_funct3(i_imem_rdata[14:12]), // branch compare select
    .o_pc(pc), .o_pc4(pc4), .o_next_pc(next_pc), .o_alu_result(alu_result), .o_valid(valid)
  );

  hart_result result_i (
    .i_inst(i_imem_rdata), .i_alu_result(alu_result), .i_rs2_data(rs2_data), .i_imm(imm),
    .i_pc4(pc4), .i_mem_read(mem_read), .i_mem_write(mem_write), .i_reg_write(reg_write),
    .i_wb_sel(wb_sel), .i_valid(valid), .i_dmem_rdata(i_dmem_rdata),
    .o_dmem_addr(o_dmem_addr), .o_dmem_ren(o_dmem_ren), .o_dmem_wen(o_dmem_wen),
    .o_dmem_wdata(o_dmem_wdata), .o_dmem_mask(o_dmem_mask),
    .o_rd_wen(rd_wen), .o_rd_wdata(rd_wdata)
  );

  assign o_imem_raddr = pc; // fetch and retire happen in the same cycle

  // every field describes the instruction now on the fetch port
  assign o_retire_valid     = valid;
  assign o_retire_inst      = i_imem_rdata;
  assign o_retire_halt      = halt;
  assign o_retire_rs1_raddr = rs1_addr;
  assign o_retire_rs2_raddr = rs2_addr;
  assign o_retire_rs1_rdata = rs1_data;
  assign o_retire_rs2_rdata = rs2_data;
  assign o_retire_rd_waddr  = rd_addr;  // already zero when rd is not written
  assign o_retire_rd_wdata  = rd_wdata;
  assign o_retire_pc        = pc;
  assign o_retire_next_pc   = next_pc;

endmodule

//--- design/hart_decode.sv
`timescale 1ns/10ps

module hart_decode import hart_pkg::*; (
  input  logic [xlen-1:0]       i_inst,
  output logic [reg_addr_w-1:0] o_rs1_addr,
  output logic [reg_addr_w-1:0] o_rs2_addr,
  output logic [reg_addr_w-1:0] o_rd_addr,
  output logic [xlen-1:0]       o_imm,
  output logic [3:0]            o_alu_op,
  output logic                  o_alu_src_imm,
  output logic                  o_alu_src_pc,
  output logic                  o_branch,
  output logic                  o_jal,
  output logic                  o_jalr,
  output logic                  o_mem_read,
  output logic                  o_mem_write,
  output logic                  o_reg_write,
  output logic [1:0]            o_wb_sel,
  output logic                  o_halt
);

  inst_u      inst;
  logic [3:0] arith_op; // alu code for the op and op-imm groups
  logic       use_rs1;
  logic       use_rs2;

  assign inst = i_inst;

  // funct7 bit 5 picks sub only for register ops, while for shifts it selects sra
  always_comb begin
    case (inst.r_view.funct3)
      3'b000:  arith_op = (inst.r_view.opcode == op_reg && inst.r_view.funct7[5]) ?
                          alu_sub : alu_add;
      3'b001:  arith_op = alu_sll;
      3'b010:  arith_op = alu_slt;
      3'b011:  arith_op = alu_sltu;
      3'b100:  arith_op = alu_xor;
      3'b101:  arith_op = inst.r_view.funct7[5] ? alu_sra : alu_srl;
      3'b110:  arith_op = alu_or;
      default: arith_op = alu_and;
    endcase
  end

  always_comb begin
    o_imm         = {{20{inst.i_view.imm12[11]}}, inst.i_view.imm12}; // i-type by default
    o_alu_op      = alu_add; // address and link arithmetic is an add
    o_alu_src_imm = 1'b0;
    o_alu_src_pc  = 1'b0;
    o_branch      = 1'b0;
    o_jal         = 1'b0;
    o_jalr        = 1'b0;
    o_mem_read    = 1'b0;
    o_mem_write   = 1'b0;
    o_reg_write   = 1'b0;
    o_wb_sel      = wb_alu;
    use_rs1       = 1'b0;
    use_rs2       = 1'b0;
    case (inst.r_view.opcode)
      op_lui: begin
        o_imm       = {inst.i_view.imm12, inst.i_view.rs1, inst.i_view.funct3, 12'b0};
        o_reg_write = 1'b1;
        o_wb_sel    = wb_imm; // the alu is not needed for lui
      end
      op_auipc: begin
        o_imm         = {inst.i_view.imm12, inst.i_view.rs1, inst.i_view.funct3, 12'b0};
        o_alu_src_pc  = 1'b1; // pc plus upper immediate
        o_alu_src_imm = 1'b1;
        o_reg_write   = 1'b1;
      end
      op_jal: begin
        // j immediate is scattered over the whole upper 20 bits
        o_imm       = {{12{inst.i_view.imm12[11]}}, inst.i_view.rs1, inst.i_view.funct3,
                       inst.i_view.imm12[0], inst.i_view.imm12[10:1], 1'b0};
        o_jal       = 1'b1;
        o_reg_write = 1'b1;
        o_wb_sel    = wb_pc4;
      end
      op_jalr: begin
        o_alu_src_imm = 1'b1; // target is rs1 plus the i immediate
        o_jalr        = 1'b1;
        o_reg_write   = 1'b1;
        o_wb_sel      = wb_pc4;
        use_rs1       = 1'b1;
      end
      op_branch: begin
        o_imm    = {{20{inst.r_view.funct7[6]}}, inst.r_view.rd[0], inst.r_view.funct7[5:0],
                    inst.r_view.rd[4:1], 1'b0};
        o_branch = 1'b1; // compare is done on the register data in execute
        use_rs1  = 1'b1;
        use_rs2  = 1'b1;
      end
      op_load: begin
        o_alu_src_imm = 1'b1;
        o_mem_read    = 1'b1;
        o_reg_write   = 1'b1;
        o_wb_sel      = wb_mem;
        use_rs1       = 1'b1;
      end
      op_store: begin
        o_imm         = {{20{inst.r_view.funct7[6]}}, inst.r_view.funct7, inst.r_view.rd};
        o_alu_src_imm = 1'b1;
        o_mem_write   = 1'b1;
        use_rs1       = 1'b1;
        use_rs2       = 1'b1; // store data
      end
      op_imm: begin
        o_alu_op      = arith_op;
        o_alu_src_imm = 1'b1;
        o_reg_write   = 1'b1;
        use_rs1       = 1'b1;
      end
      op_reg: begin
        o_alu_op    = arith_op;
        o_reg_write = 1'b1;
        use_rs1     = 1'b1;
        use_rs2     = 1'b1;
      end
      default: ; // fence and the other system words act as a nop
    endcase
  end

  // unused register fields report as x0 on the retire port
  assign o_rs1_addr = use_rs1     ? inst.r_view.rs1 : '0;
  assign o_rs2_addr = use_rs2     ? inst.r_view.rs2 : '0;
  assign o_rd_addr  = o_reg_write ? inst.r_view.rd  : '0;
  assign o_halt     = (inst.r_view.opcode == op_system) && (i_inst == ebreak_word);

  // the data port can only do one access per cycle
  always_comb begin
    assert final (!(o_mem_read && o_mem_write))
      else $error("decode requested a load and a store together");
  end

endmodule

//--- design/hart_execute.sv
`timescale 1ns/10ps

module hart_execute import hart_pkg::*; #(
  parameter logic [xlen-1:0] RESET_ADDR = '0
) (
  input  logic            i_clk,
  input  logic            i_rst,
  input  logic            i_halt,
  input  logic [xlen-1:0] i_rs1_data,
  input  logic [xlen-1:0] i_rs2_data,
  input  logic [xlen-1:0] i_imm,
  input  logic [3:0]      i_alu_op,
  input  logic            i_alu_src_imm,
  input  logic            i_alu_src_pc,
  input  logic            i_branch,
  input  logic            i_jal,
  input  logic            i_jalr,
  input  logic [2:0]      i_funct3,
  output logic [xlen-1:0] o_pc,
  output logic [xlen-1:0] o_pc4,
  output logic [xlen-1:0] o_next_pc,
  output logic [xlen-1:0] o_alu_result,
  output logic            o_valid
);

  logic            halted; // set once ebreak has retired
  logic [xlen-1:0] op_a;
  logic [xlen-1:0] op_b;
  logic [4:0]      shamt;
  logic            cond;   // branch comparison chosen by funct3

  assign op_a  = i_alu_src_pc  ? o_pc  : i_rs1_data; // pc only for auipc
  assign op_b  = i_alu_src_imm ? i_imm : i_rs2_data;
  assign shamt = op_b[4:0];

  always_comb begin
    case (i_alu_op)
      alu_sub:  o_alu_result = op_a - op_b;
      alu_sll:  o_alu_result = op_a << shamt;
      alu_slt:  o_alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
      alu_sltu: o_alu_result = {31'b0, op_a < op_b};
      alu_xor:  o_alu_result = op_a ^ op_b;
      alu_srl:  o_alu_result = op_a >> shamt;
      alu_sra:  o_alu_result = $signed(op_a) >>> shamt;
      alu_or:   o_alu_result = op_a | op_b;
      alu_and:  o_alu_result = op_a & op_b;
      default:  o_alu_result = op_a + op_b; // alu_add, also addresses and jalr target
    endcase
  end

  // branches compare the raw register data, not the alu operands
  always_comb begin
    case (i_funct3)
      3'b000:  cond = i_rs1_data == i_rs2_data;
      3'b001:  cond = i_rs1_data != i_rs2_data;
      3'b100:  cond = $signed(i_rs1_data) <  $signed(i_rs2_data);
      3'b101:  cond = $signed(i_rs1_data) >= $signed(i_rs2_data);
      3'b110:  cond = i_rs1_data <  i_rs2_data;
      3'b111:  cond = i_rs1_data >= i_rs2_data;
      default: cond = 1'b0;
    endcase
  end

  assign o_pc4 = o_pc + 32'd4;

  always_comb begin
    if ((i_branch && cond) || i_jal) o_next_pc = o_pc + i_imm;
    else if (i_jalr)                 o_next_pc = {o_alu_result[xlen-1:1], 1'b0};
    else                             o_next_pc = o_pc4;
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_pc   <= RESET_ADDR;
      halted <= 1'b0;
    end else if (!halted) begin
      o_pc   <= o_next_pc;
      halted <= i_halt; // pc freezes from the edge after ebreak
    end
  end

  assign o_valid = !i_rst && !halted; // one retire per clock while running

  // misaligned jump targets are not trapped, so this catches a bad program or decode
  assert property (@(posedge i_clk) disable iff (i_rst) o_pc[1:0] == 2'b00)
    else $error("pc left word alignment");

endmodule

//--- design/hart_pkg.sv
package hart_pkg;

  localparam int xlen       = 32; // data and address width
  localparam int reg_addr_w = 5;  // register index width

  // base opcodes of the rv32i subset this hart executes
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_reg    = 7'b0110011;
  localparam logic [6:0] op_system = 7'b1110011;

  // only this exact system word is recognized, it stops the hart
  localparam logic [31:0] ebreak_word = 32'h0010_0073;

  // alu operation codes
  localparam logic [3:0] alu_add  = 4'd0;
  localparam logic [3:0] alu_sub  = 4'd1;
  localparam logic [3:0] alu_sll  = 4'd2;
  localparam logic [3:0] alu_slt  = 4'd3;
  localparam logic [3:0] alu_sltu = 4'd4;
  localparam logic [3:0] alu_xor  = 4'd5;
  localparam logic [3:0] alu_srl  = 4'd6;
  localparam logic [3:0] alu_sra  = 4'd7;
  localparam logic [3:0] alu_or   = 4'd8;
  localparam logic [3:0] alu_and  = 4'd9;

  // writeback source for the destination register
  localparam logic [1:0] wb_alu = 2'd0; // alu result, also auipc
  localparam logic [1:0] wb_mem = 2'd1; // extended load data
  localparam logic [1:0] wb_pc4 = 2'd2; // link address of jal and jalr
  localparam logic [1:0] wb_imm = 2'd3; // upper immediate of lui

  // one instruction word read through two field layouts
  // the s, b, u and j immediates are assembled from these same bit ranges
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r_view;
    struct packed {
      logic [11:0] imm12;  // inst[31:20]
      logic [4:0]  rs1;    // inst[19:15]
      logic [2:0]  funct3; // inst[14:12]
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i_view;
  } inst_u;

endpackage

//--- design/hart_regfile.sv
`timescale 1ns/10ps

module hart_regfile (
  input  logic        i_clk,
  input  logic        i_rst,
  input  logic [4:0]  i_rs1_addr,
  input  logic [4:0]  i_rs2_addr,
  input  logic [4:0]  i_rd_addr,
  input  logic        i_rd_wen,
  input  logic [31:0] i_rd_wdata,
  output logic [31:0] o_rs1_rdata,
  output logic [31:0] o_rs2_rdata
);

  logic [31:0] regs [1:31]; // x0 has no storage at all

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int i = 1; i < 32; i++) regs[i] <= '0;
    end else if (i_rd_wen && i_rd_addr != 5'd0) begin
      regs[i_rd_addr] <= i_rd_wdata; // lands at the edge, so a same-cycle read sees the old value
    end
  end

  assign o_rs1_rdata = (i_rs1_addr == 5'd0) ? '0 : regs[i_rs1_addr];
  assign o_rs2_rdata = (i_rs2_addr == 5'd0) ? '0 : regs[i_rs2_addr];

  // a write aimed at x0 must leave nothing behind for the next reader
  assert property (@(posedge i_clk) disable iff (i_rst)
    (i_rd_wen && i_rd_addr == 5'd0) |=>
      (i_rs1_addr != 5'd0 || o_rs1_rdata == '0) && (i_rs2_addr != 5'd0 || o_rs2_rdata == '0))
    else $error("x0 picked up a written value");

endmodule

//--- design/hart_result.sv
`timescale 1ns/10ps

module hart_result import hart_pkg::*; (
  input  logic [xlen-1:0] i_inst,
  input  logic [xlen-1:0] i_alu_result,
  input  logic [xlen-1:0] i_rs2_data,
  input  logic [xlen-1:0] i_imm,
  input  logic [xlen-1:0] i_pc4,
  input  logic            i_mem_read,
  input  logic            i_mem_write,
  input  logic            i_reg_write,
  input  logic [1:0]      i_wb_sel,
  input  logic            i_valid,
  input  logic [xlen-1:0] i_dmem_rdata,
  output logic [xlen-1:0] o_dmem_addr,
  output logic            o_dmem_ren,
  output logic            o_dmem_wen,
  output logic [xlen-1:0] o_dmem_wdata,
  output logic [3:0]      o_dmem_mask,
  output logic            o_rd_wen,
  output logic [xlen-1:0] o_rd_wdata
);

  inst_u           inst;
  logic [2:0]      funct3;   // bits 1:0 give the size, bit 2 means zero extend
  logic [1:0]      offset;   // byte offset inside the aligned word
  logic [xlen-1:0] lane;     // load word shifted so the wanted bytes sit at bit 0
  logic [xlen-1:0] load_data;

  assign inst   = i_inst;
  assign funct3 = inst.r_view.funct3;
  assign offset = i_alu_result[1:0];

  assign o_dmem_addr = {i_alu_result[xlen-1:2], 2'b00};

  always_comb begin
    case (funct3[1:0])
      2'b00:   o_dmem_mask = 4'b0001 << offset;
      2'b01:   o_dmem_mask = 4'b0011 << {offset[1], 1'b0}; // half offset is 0 or 2
      default: o_dmem_mask = 4'b1111;
    endcase
  end

  // store data moves up into the lane the mask opens, the rest is ignored by memory
  assign o_dmem_wdata = i_rs2_data << {offset, 3'b000};

  assign lane = i_dmem_rdata >> {offset, 3'b000};

  always_comb begin
    case (funct3[1:0])
      2'b00:   load_data = funct3[2] ? {24'b0, lane[7:0]} : {{24{lane[7]}}, lane[7:0]};
      2'b01:   load_data = funct3[2] ? {16'b0, lane[15:0]} : {{16{lane[15]}}, lane[15:0]};
      default: load_data = lane; // lw
    endcase
  end

  always_comb begin
    case (i_wb_sel)
      wb_mem:  o_rd_wdata = load_data;
      wb_pc4:  o_rd_wdata = i_pc4;  // return address
      wb_imm:  o_rd_wdata = i_imm;
      default: o_rd_wdata = i_alu_result;
    endcase
  end

  // nothing reaches memory or the register file while in reset or halted
  assign o_dmem_ren = i_mem_read  && i_valid;
  assign o_dmem_wen = i_mem_write && i_valid;
  assign o_rd_wen   = i_reg_write && i_valid;

  always_comb begin
    assert final (!(o_dmem_ren && o_dmem_wen))
      else $error("data port read and write enabled together");
  end

endmodule

//--- sim.f
design/hart_pkg.sv
design/hart_decode.sv
design/hart_regfile.sv
design/hart_execute.sv
design/hart_result.sv
design/hart.sv
tb/tb_memory.sv
tb/hart_tb.sv

//--- tb/hart_tb.sv
`timescale 1ns/10ps

module hart_tb import hart_pkg::*; ();

  localparam logic [31:0] start_addr = 32'h0000_0100;
  localparam logic [31:0] data_base  = 32'h0000_0600; // stores and loads land above the program
  // bit 3 is funct7 bit 5, bits 2:0 are funct3, one entry per alu operation
  localparam logic [3:0] alu_mix [10] = '{4'b0000, 4'b1000, 4'b0001, 4'b0010, 4'b0011,
                                          4'b0100, 4'b0101, 4'b1101, 4'b0110, 4'b0111};
  localparam logic [2:0] br_f3 [6] = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};

  logic        clk = 1'b0;
  logic        rst;
  logic [31:0] imem_raddr, imem_rdata, dmem_addr, dmem_wdata, dmem_rdata;
  logic        dmem_ren, dmem_wen;
  logic [3:0]  dmem_mask;
  logic        retire_valid, retire_halt;
  logic [31:0] retire_inst, rs1_rdata, rs2_rdata, rd_wdata, retire_pc, retire_next_pc;
  logic [4:0]  rs1_raddr, rs2_raddr, rd_waddr;
  logic [31:0] rng;
  logic [31:0] prog_addr;
  logic [31:0] prev_next_pc;
  logic [31:0] xreg [32];      // register values the program has produced so far
  logic        have_prev = 1'b0;
  logic        halt_seen = 1'b0; // ebreak has retired
  int          cycles;

  hart #(.RESET_ADDR(start_addr)) dut_i (
    .i_clk(clk), .i_rst(rst), .o_imem_raddr(imem_raddr), .i_imem_rdata(imem_rdata),
    .o_dmem_addr(dmem_addr), .o_dmem_ren(dmem_ren), .o_dmem_wen(dmem_wen),
    .o_dmem_wdata(dmem_wdata), .o_dmem_mask(dmem_mask), .i_dmem_rdata(dmem_rdata),
    .o_retire_valid(retire_valid), .o_retire_inst(retire_inst), .o_retire_halt(retire_halt),
    .o_retire_rs1_raddr(rs1_raddr), .o_retire_rs2_raddr(rs2_raddr),
    .o_retire_rs1_rdata(rs1_rdata), .o_retire_rs2_rdata(rs2_rdata),
    .o_retire_rd_waddr(rd_waddr), .o_retire_rd_wdata(rd_wdata),
    .o_retire_pc(retire_pc), .o_retire_next_pc(retire_next_pc)
  );

  tb_memory mem_i (
    .i_clk(clk), .i_rst(rst), .i_imem_raddr(imem_raddr), .o_imem_rdata(imem_rdata),
    .i_dmem_addr(dmem_addr), .i_dmem_wen(dmem_wen), .i_dmem_wdata(dmem_wdata),
    .i_dmem_mask(dmem_mask), .o_dmem_rdata(dmem_rdata)
  );

  always #10 clk = ~clk;

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
    $display("** FAIL **");
    $fatal(1, "value mismatch");
  endtask

  task automatic stop_run(input string msg);
    $display("%0t: %s", $time, msg);
    $display("** FAIL **");
    $fatal(1, "run stopped");
  endtask

  function automatic logic [31:0] xorshift32();
    rng ^= rng << 13;
    rng ^= rng >> 17;
    rng ^= rng << 5;
    return rng;
  endfunction

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2, rs1,
                                         input logic [2:0] f3, input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, op_reg};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2, rs1,
                                         input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], op_store};
  endfunction

  function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2, rs1,
                                         input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
  endfunction

  // immediate by instruction format, read straight from the rv32i bit layout
  function automatic logic [31:0] imm_of(input logic [31:0] inst);
    case (inst[6:0])
      op_lui, op_auipc: return {inst[31:12], 12'b0};
      op_jal:    return {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
      op_branch: return {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
      op_store:  return {{20{inst[31]}}, inst[31:25], inst[11:7]};
      default:   return {{20{inst[31]}}, inst[31:20]};
    endcase
  endfunction

  // register fields a format does not use are reported as x0
  function automatic logic [4:0] rs1_field(input logic [31:0] inst);
    return (inst[6:0] inside {op_jalr, op_branch, op_load, op_store, op_imm, op_reg}) ?
           inst[19:15] : 5'd0;
  endfunction

  function automatic logic [4:0] rs2_field(input logic [31:0] inst);
    return (inst[6:0] inside {op_branch, op_store, op_reg}) ? inst[24:20] : 5'd0;
  endfunction

  function automatic logic [4:0] rd_field(input logic [31:0] inst);
    return (inst[6:0] inside {op_lui, op_auipc, op_jal, op_jalr, op_load, op_imm, op_reg}) ?
           inst[11:7] : 5'd0;
  endfunction

  function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a, b);
    case (f3)
      3'b000:  return a == b;
      3'b001:  return a != b;
      3'b100:  return $signed(a) < $signed(b);
      3'b101:  return $signed(a) >= $signed(b);
      3'b110:  return a < b;
      default: return a >= b;
    endcase
  endfunction

  function automatic logic [31:0] next_pc_ref(input logic [31:0] inst, pc, a, b);
    case (inst[6:0])
      op_jal:    return pc + imm_of(inst);
      op_jalr:   return (a + imm_of(inst)) & ~32'd1; // bit 0 of the target is dropped
      op_branch: return branch_taken(inst[14:12], a, b) ? pc + imm_of(inst) : pc + 32'd4;
      default:   return pc + 32'd4;
    endcase
  endfunction

  // value written to rd by lui, auipc, the jumps and the alu groups
  function automatic logic [31:0] wb_ref(input logic [31:0] inst, pc, a, b);
    logic [31:0] y;
    logic [4:0]  sh;
    y  = (inst[6:0] == op_imm) ? imm_of(inst) : b;
    sh = y[4:0];
    if (inst[6:0] == op_lui) return imm_of(inst);
    if (inst[6:0] == op_auipc) return pc + imm_of(inst);
    if (inst[6:0] == op_jal || inst[6:0] == op_jalr) return pc + 32'd4;
    case (inst[14:12])
      3'b000:  return (inst[6:0] == op_reg && inst[30]) ? a - y : a + y;
      3'b001:  return a << sh;
      3'b010:  return {31'b0, $signed(a) < $signed(y)};
      3'b011:  return {31'b0, a < y};
      3'b100:  return a ^ y;
      3'b101:  return inst[30] ? 32'($signed(a) >>> sh) : a >> sh;
      3'b110:  return a | y;
      default: return a & y;
    endcase
  endfunction

  function automatic logic [31:0] load_extend(input logic [31:0] word, input logic [1:0] off,
                                              input logic [2:0] f3);
    logic [31:0] lane;
    lane = word >> {off, 3'b000};
    case (f3)
      3'b000:  return {{24{lane[7]}}, lane[7:0]};
      3'b001:  return {{16{lane[15]}}, lane[15:0]};
      3'b100:  return {24'b0, lane[7:0]};
      3'b101:  return {16'b0, lane[15:0]};
      default: return lane;
    endcase
  endfunction

  function automatic logic [3:0] store_mask(input logic [2:0] f3, input logic [1:0] off);
    case (f3[1:0])
      2'b00:   return 4'b0001 << off;
      2'b01:   return 4'b0011 << off; // halves sit at offset 0 or 2
      default: return 4'b1111;
    endcase
  endfunction

  task automatic emit(input logic [31:0] word);
    mem_i.rom[prog_addr[11:2]] = word;
    prog_addr += 32'd4;
  endtask

  task automatic build_program();
    logic [31:0] r;
    logic [11:0] imm;
    logic [11:0] ob, oh, ow;
    logic [31:0] filler;
    filler    = i_type(12'd1, 5'd22, 3'b000, 5'd22, op_imm); // skipped slot after a branch
    prog_addr = start_addr;
    for (int k = 1; k <= 4; k++) begin
      r = xorshift32();
      emit({r[31:12], 5'(k), op_lui});
      emit(i_type(r[11:0], 5'(k), 3'b000, 5'(k), op_imm));
    end
    // every alu operation in register form, and in immediate form except sub
    for (int k = 0; k < 10; k++) begin
      r = xorshift32();
      emit(r_type({1'b0, alu_mix[k][3], 5'b0}, 5'(1 + (k + 1) % 4), 5'(1 + k % 4),
                  alu_mix[k][2:0], 5'(5 + k)));
      if (k != 1) begin
        if (alu_mix[k][1:0] == 2'b01) imm = {1'b0, alu_mix[k][3], 5'b0, r[4:0]};
        else imm = r[11:0];
        emit(i_type(imm, 5'(1 + k % 4), alu_mix[k][2:0], 5'(5 + k), op_imm));
      end
    end
    emit({r[31:12], 5'd15, op_auipc});
    emit(i_type(data_base[11:0], 5'd0, 3'b000, 5'd16, op_imm));
    r  = xorshift32();
    ob = {3'b0, r[8:0]};
    oh = {3'b0, r[17:10], 1'b0};
    ow = {3'b0, r[27:21], 2'b00};
    emit(s_type(ob, 5'd1, 5'd16, 3'b000));
    emit(s_type(oh, 5'd2, 5'd16, 3'b001));
    emit(s_type(ow, 5'd3, 5'd16, 3'b010));
    emit(i_type(ob, 5'd16, 3'b000, 5'd17, op_load));
    emit(i_type(ob, 5'd16, 3'b100, 5'd18, op_load));
    emit(i_type(oh, 5'd16, 3'b001, 5'd19, op_load));
    emit(i_type(oh, 5'd16, 3'b101, 5'd20, op_load));
    emit(i_type(ow, 5'd16, 3'b010, 5'd21, op_load));
    // operand pairs are swapped so each kind goes both ways
    foreach (br_f3[k]) begin
      emit(b_type(13'd8, br_f3[k][2] ? 5'd2 : 5'd1, 5'd1, br_f3[k]));
      emit(filler);
      emit(b_type(13'd8, br_f3[k][2] ? 5'd1 : 5'd2, br_f3[k][2] ? 5'd2 : 5'd1, br_f3[k]));
      emit(filler);
    end
    emit({1'b0, 10'd4, 1'b0, 8'd0, 5'd23, op_jal}); // jal x23 over one slot
    emit(filler);
    emit({20'd0, 5'd25, op_auipc});
    emit(i_type(12'd13, 5'd25, 3'b000, 5'd24, op_jalr)); // odd offset, lands on pc+12
    emit(filler);
    emit(ebreak_word);
  endtask

  always @(posedge clk) begin : check_retire
    logic [31:0] inst, ea, exp, lanes;
    logic [3:0]  mask;
    inst = retire_inst;
    ea   = rs1_rdata + imm_of(inst);
    if (rst) begin
      assert (!retire_valid && !dmem_ren && !dmem_wen)
        else stop_run("retire or data port active during reset");
    end else if (halt_seen) begin
      assert (!retire_valid) else stop_run("an instruction retired after the halt");
    end else if (retire_valid) begin
      exp = have_prev ? prev_next_pc : start_addr;
      assert (retire_pc == exp) else report_mismatch("o_retire_pc", retire_pc, exp);
      assert (imem_raddr == exp) else report_mismatch("o_imem_raddr", imem_raddr, exp);
      assert (inst == mem_i.rom[exp[11:2]])
        else report_mismatch("o_retire_inst", inst, mem_i.rom[exp[11:2]]);
      exp = next_pc_ref(inst, retire_pc, rs1_rdata, rs2_rdata);
      assert (retire_next_pc == exp)
        else report_mismatch("o_retire_next_pc", retire_next_pc, exp);
      assert (rs1_raddr == rs1_field(inst))
        else report_mismatch("o_retire_rs1_raddr", 32'(rs1_raddr), 32'(rs1_field(inst)));
      assert (rs2_raddr == rs2_field(inst))
        else report_mismatch("o_retire_rs2_raddr", 32'(rs2_raddr), 32'(rs2_field(inst)));
      assert (rd_waddr == rd_field(inst))
        else report_mismatch("o_retire_rd_waddr", 32'(rd_waddr), 32'(rd_field(inst)));
      // the read data must be what earlier instructions left in those registers
      assert (rs1_rdata == xreg[rs1_raddr])
        else report_mismatch("o_retire_rs1_rdata", rs1_rdata, xreg[rs1_raddr]);
      assert (rs2_rdata == xreg[rs2_raddr])
        else report_mismatch("o_retire_rs2_rdata", rs2_rdata, xreg[rs2_raddr]);
      assert (dmem_ren == (inst[6:0] == op_load))
        else report_mismatch("o_dmem_ren", {31'b0, dmem_ren}, {31'b0, inst[6:0] == op_load});
      assert (dmem_wen == (inst[6:0] == op_store))
        else report_mismatch("o_dmem_wen", {31'b0, dmem_wen}, {31'b0, inst[6:0] == op_store});
      assert (retire_halt == (inst == ebreak_word))
        else report_mismatch("o_retire_halt", {31'b0, retire_halt},
                             {31'b0, inst == ebreak_word});
      if (inst[6:0] inside {op_lui, op_auipc, op_jal, op_jalr, op_imm, op_reg}) begin
        exp = wb_ref(inst, retire_pc, rs1_rdata, rs2_rdata);
        assert (rd_wdata == exp) else report_mismatch("o_retire_rd_wdata", rd_wdata, exp);
      end
      if (inst[6:0] == op_store) begin
        mask  = store_mask(inst[14:12], ea[1:0]);
        lanes = {{8{mask[3]}}, {8{mask[2]}}, {8{mask[1]}}, {8{mask[0]}}};
        exp   = rs2_rdata << {ea[1:0], 3'b000};
        assert (dmem_addr == {ea[31:2], 2'b00})
          else report_mismatch("o_dmem_addr", dmem_addr, {ea[31:2], 2'b00});
        assert (dmem_mask == mask)
          else report_mismatch("o_dmem_mask", {28'b0, dmem_mask}, {28'b0, mask});
        assert ((dmem_wdata & lanes) == (exp & lanes))
          else report_mismatch("o_dmem_wdata", dmem_wdata & lanes, exp & lanes);
        mem_i.record_store(ea, exp, mask);
      end
      if (inst[6:0] == op_load) begin
        exp = load_extend(dmem_rdata, ea[1:0], inst[14:12]);
        assert (rd_wdata == exp) else report_mismatch("o_retire_rd_wdata", rd_wdata, exp);
        // the word read back must hold what the earlier stores put there
        assert (exp == load_extend(mem_i.shadow_word(ea), ea[1:0], inst[14:12]))
          else report_mismatch("i_dmem_rdata", exp,
                               load_extend(mem_i.shadow_word(ea), ea[1:0], inst[14:12]));
      end
      if (inst == ebreak_word) halt_seen = 1'b1;
      if (rd_waddr != 5'd0) xreg[rd_waddr] = rd_wdata; // every value written here was checked
      prev_next_pc = retire_next_pc;
      have_prev    = 1'b1;
    end
  end

  initial begin
    rst = 1'b1;
    rng = 32'hf0b8_746b;
    foreach (xreg[i]) xreg[i] = '0;
    build_program();
    mem_i.clear_shadow();
    repeat (8) @(negedge clk);
    rst    = 1'b0;
    cycles = 0;
    while (!halt_seen && cycles < 2000) begin
      @(negedge clk);
      cycles++;
    end
    if (!halt_seen) begin
      stop_run("timeout, ebreak did not retire within 2000 cycles");
    end else begin
      for (int i = 0; i < 10; i++) @(negedge clk); // checker watches retire stay low
      $display("** PASS **");
      $finish;
    end
  end

endmodule

//--- tb/tb_memory.sv
`timescale 1ns/10ps

module tb_memory #(
  parameter int AW = 10 // word address bits, so 4 KB in all
) (
  input  logic        i_clk,
  input  logic        i_rst,
  input  logic [31:0] i_imem_raddr,
  output logic [31:0] o_imem_rdata,
  input  logic [31:0] i_dmem_addr,
  input  logic        i_dmem_wen,
  input  logic [31:0] i_dmem_wdata,
  input  logic [3:0]  i_dmem_mask,
  output logic [31:0] o_dmem_rdata
);

  logic [31:0]   rom [2**AW];     // program words, filled by the testbench
  logic [31:0]   ram [2**AW];
  logic [3:0]    written [2**AW]; // bytes the hart has stored since reset
  logic [31:0]   shadow [2**AW];  // contents the checker expects
  logic [AW-1:0] widx;
  logic [31:0]   fill;

  // unwritten data bytes read back as a pattern of the full word address
  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return ({addr[31:2], 2'b00} * 32'h9e37_79b1) ^ 32'h6d2b_79f5;
  endfunction

  assign o_imem_rdata = rom[i_imem_raddr[AW+1:2]]; // same-cycle fetch
  assign widx = i_dmem_addr[AW+1:2];
  assign fill = fill_word(i_dmem_addr);

  always_comb begin
    for (int b = 0; b < 4; b++) begin
      o_dmem_rdata[8*b +: 8] = written[widx][b] ? ram[widx][8*b +: 8] : fill[8*b +: 8];
    end
  end

  // only the lanes opened by the mask change, at the edge that ends the store cycle
  always @(posedge i_clk) begin
    if (i_rst) begin
      for (int i = 0; i < 2**AW; i++) written[i] <= 4'b0000;
    end else if (i_dmem_wen) begin
      for (int b = 0; b < 4; b++) begin
        if (i_dmem_mask[b]) begin
          ram[widx][8*b +: 8] <= i_dmem_wdata[8*b +: 8];
          written[widx][b]    <= 1'b1;
        end
      end
    end
  end

  task automatic clear_shadow();
    for (int i = 0; i < 2**AW; i++) shadow[i] = fill_word(32'(i) << 2);
  endtask

  // the checker records each store as it expects it to land
  task automatic record_store(input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] mask);
    for (int b = 0; b < 4; b++) begin
      if (mask[b]) shadow[addr[AW+1:2]][8*b +: 8] = data[8*b +: 8];
    end
  endtask

  function automatic logic [31:0] shadow_word(input logic [31:0] addr);
    return shadow[addr[AW+1:2]];
  endfunction

endmodule
